// ==== design/tx_dac_pkg.sv ====
// shared widths and enums for the transmit converter interface: sample sizes, antenna mode, pacer phase
package tx_dac_pkg;

    parameter int iq_width       = 16;           // bits of I or of Q
    parameter int sample_width   = 2 * iq_width; // one complex sample with I in the upper half
    parameter int dac_word_width = 2 * sample_width; // lane A upper 32 bits, lane B lower 32 bits

    // antenna mode as seen by the lane mapper in the converter domain
    typedef enum logic [1:0] {
        ant_a   = 2'd0, // sample on lane A, zero on lane B
        ant_b   = 2'd1, // sample on lane B, zero on lane A
        ant_cdd = 2'd2  // sample on lane A, one baseband sample older on lane B
    } ant_mode_e;

    // phase of the acc domain pacer within one sample period
    typedef enum logic [1:0] {
        ph_sample = 2'd0, // write word carries the baseband sample
        ph_zero   = 2'd1, // write word carries the inserted zero
        ph_idle   = 2'd2  // no write this cycle
    } pacer_state_e;

endpackage

// ==== design/bb_sample_pacer.sv ====
// acc domain pacer that pops the baseband FIFO once per period and writes sample then zero
`timescale 1ns/1ps

module bb_sample_pacer #(
    parameter int clk_per_sample = 4 // acc_clk cycles per baseband sample, at least 2
) (
    input  logic                                acc_clk,
    input  logic                                acc_rstn,
    input  logic                                tx_en,         // level, may drop at any time
    input  logic [tx_dac_pkg::sample_width-1:0] data_from_acc, // head word of the upstream FIFO
    output logic                                read_bb_fifo,  // one cycle pop of the upstream FIFO
    output logic                                read_bb_fifo_delay,
    output logic                                wr_en,         // two cycles per period
    output logic [tx_dac_pkg::sample_width-1:0] wr_data
);

    localparam int cnt_width = $clog2(clk_per_sample);
    localparam logic [cnt_width-1:0] cnt_top = cnt_width'(clk_per_sample - 1);

    logic [cnt_width-1:0]     cnt;   // position inside the current sample period
    tx_dac_pkg::pacer_state_e phase; // what the write port carries this cycle
    logic                     start; // a new period begins on this edge

    // a period only starts from count zero, so a falling tx_en lets the running one finish
    assign start = tx_en && (cnt == '0);

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            cnt <= '0;
        end else if (start || cnt != '0) begin
            cnt <= (cnt == cnt_top) ? '0 : cnt + 1'b1; // wraps to zero at the end of the period
        end
    end

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            read_bb_fifo       <= 1'b0;
            read_bb_fifo_delay <= 1'b0;
        end else begin
            read_bb_fifo       <= start;        // upstream pops on the following edge
            read_bb_fifo_delay <= read_bb_fifo; // same pulse one cycle later
        end
    end

    // the head word is still valid on the edge that pops it, so the sample is captured there
    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            phase <= tx_dac_pkg::ph_idle;
        end else if (read_bb_fifo) begin
            phase <= tx_dac_pkg::ph_sample; // sample write follows the pop edge
        end else if (phase == tx_dac_pkg::ph_sample) begin
            phase <= tx_dac_pkg::ph_zero;   // zero insertion for 2x interpolation
        end else begin
            phase <= tx_dac_pkg::ph_idle;
        end
    end

    always_ff @(posedge acc_clk) begin
        if (read_bb_fifo) begin
            wr_data <= data_from_acc; // latch the head word as it leaves upstream
        end else if (phase == tx_dac_pkg::ph_sample) begin
            wr_data <= '0;            // second write of the period is a zero sample
        end
    end

    assign wr_en = (phase != tx_dac_pkg::ph_idle); // high in ph_sample and ph_zero only

endmodule

// ==== design/async_sample_fifo.sv ====
// dual-clock first-word-fall-through sample FIFO with Gray pointers and sticky overflow
`timescale 1ns/1ps

module async_sample_fifo #(
    parameter int fifo_addr_width = 5 // depth is 2**fifo_addr_width
) (
    input  logic                                acc_clk,
    input  logic                                acc_rstn,
    input  logic                                wr_en,
    input  logic [tx_dac_pkg::sample_width-1:0] wr_data,
    input  logic                                dac_clk,
    input  logic                                dac_rst,
    input  logic                                rd_en,    // pop, only honoured when not empty
    output logic [tx_dac_pkg::sample_width-1:0] rd_data,  // head word, valid with rd_valid
    output logic                                rd_valid, // FIFO not empty
    output logic                                overflow  // a write was dropped since reset
);

    localparam int depth = 2 ** fifo_addr_width;
    localparam int aw    = fifo_addr_width;

    logic [tx_dac_pkg::sample_width-1:0] mem [depth];

    logic [aw:0] wr_bin;       // write pointer with wrap bit, acc domain
    logic [aw:0] wr_gray;
    logic [aw:0] rd_gray_acc1; // read pointer crossing into acc domain
    logic [aw:0] rd_gray_acc2;
    logic [aw:0] rd_bin;       // read pointer with wrap bit, dac domain
    logic [aw:0] rd_gray;
    logic [aw:0] wr_gray_dac1; // write pointer crossing into dac domain
    logic [aw:0] wr_gray_dac2;
    logic        full;
    logic        empty;
    logic        wr_do;        // accepted write
    logic        rd_do;        // accepted pop

    function automatic logic [aw:0] bin2gray(input logic [aw:0] b);
        return b ^ (b >> 1);
    endfunction

    // full when the pointers differ only in the two top Gray bits
    assign full  = (wr_gray == (rd_gray_acc2 ^ {2'b11, {(aw - 1){1'b0}}}));
    assign wr_do = wr_en && !full;

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_do) begin
            wr_bin  <= wr_bin + 1'b1;
            wr_gray <= bin2gray(wr_bin + 1'b1); // registered so only one bit toggles per write
        end
    end

    always_ff @(posedge acc_clk) begin
        if (wr_do) begin
            mem[wr_bin[aw-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            overflow <= 1'b0;
        end else if (wr_en && full) begin
            overflow <= 1'b1; // sticky until the next acc reset
        end
    end

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            rd_gray_acc1 <= '0;
            rd_gray_acc2 <= '0;
        end else begin
            rd_gray_acc1 <= rd_gray;      // first flop may go metastable
            rd_gray_acc2 <= rd_gray_acc1;
        end
    end

    assign empty = (rd_gray == wr_gray_dac2); // pointers equal including the wrap bit
    assign rd_do = rd_en && !empty;

    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (rd_do) begin
            rd_bin  <= rd_bin + 1'b1;
            rd_gray <= bin2gray(rd_bin + 1'b1);
        end
    end

    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            wr_gray_dac1 <= '0;
            wr_gray_dac2 <= '0;
        end else begin
            wr_gray_dac1 <= wr_gray;
            wr_gray_dac2 <= wr_gray_dac1; // a new word shows up two dac_clk edges after its write
        end
    end

    assign rd_data  = mem[rd_bin[aw-1:0]]; // fall-through read of the head entry
    assign rd_valid = !empty;

endmodule

// ==== design/ant_mode_sync.sv ====
// antenna and CDD flag synchronizer into dac_clk with antenna mode encoding
`timescale 1ns/1ps

module ant_mode_sync #(
    parameter int sync_stages = 4 // destination flops, legal range 2 to 6
) (
    input  logic                  acc_clk,
    input  logic                  acc_rstn,
    input  logic                  dac_clk,
    input  logic                  dac_rst,
    input  logic                  ant_flag,        // 1 selects lane B
    input  logic                  simple_cdd_flag, // overrides ant_flag when set
    output tx_dac_pkg::ant_mode_e ant_mode
);

    logic                   ant_src;  // source register so only flop outputs cross
    logic                   cdd_src;
    logic [sync_stages-1:0] ant_sync; // bit 0 is the first flop after the crossing
    logic [sync_stages-1:0] cdd_sync;

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            ant_src <= 1'b0;
            cdd_src <= 1'b0;
        end else begin
            ant_src <= ant_flag;
            cdd_src <= simple_cdd_flag;
        end
    end

    // the flags are changed only while the stream is quiet, so skew between the two is harmless
    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            ant_sync <= '0;
            cdd_sync <= '0;
        end else begin
            ant_sync <= {ant_sync[sync_stages-2:0], ant_src};
            cdd_sync <= {cdd_sync[sync_stages-2:0], cdd_src};
        end
    end

    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            ant_mode <= tx_dac_pkg::ant_a;
        end else if (cdd_sync[sync_stages-1]) begin
            ant_mode <= tx_dac_pkg::ant_cdd; // CDD wins regardless of the antenna flag
        end else if (ant_sync[sync_stages-1]) begin
            ant_mode <= tx_dac_pkg::ant_b;
        end else begin
            ant_mode <= tx_dac_pkg::ant_a;
        end
    end

endmodule

// ==== design/dac_lane_mapper.sv ====
// converter word packer with a two-pop delay line for cyclic delay diversity
`timescale 1ns/1ps

module dac_lane_mapper (
    input  logic                                  dac_clk,
    input  logic                                  dac_rst,
    input  logic                                  pop,      // head word accepted by the converter
    input  logic [tx_dac_pkg::sample_width-1:0]   rd_data,  // head word of the sample FIFO
    input  logic                                  rd_valid,
    input  tx_dac_pkg::ant_mode_e                 ant_mode,
    output logic [tx_dac_pkg::dac_word_width-1:0] dac_data, // lane A upper, lane B lower
    output logic                                  dac_valid
);

    logic [tx_dac_pkg::sample_width-1:0] dly1;   // last popped word
    logic [tx_dac_pkg::sample_width-1:0] dly2;   // word popped before that
    logic [tx_dac_pkg::dac_word_width-1:0] word; // packed lanes before the valid gate

    // stream alternates sample and zero, so two pops back is one baseband sample back
    always_ff @(posedge dac_clk) begin
        if (dac_rst) begin
            dly1 <= '0;
            dly2 <= '0;
        end else if (pop) begin
            dly1 <= rd_data;
            dly2 <= dly1; // holds still under back-pressure
        end
    end

    always_comb begin
        case (ant_mode)
            tx_dac_pkg::ant_a: begin
                word = {rd_data, {tx_dac_pkg::sample_width{1'b0}}};
            end
            tx_dac_pkg::ant_b: begin
                word = {{tx_dac_pkg::sample_width{1'b0}}, rd_data};
            end
            tx_dac_pkg::ant_cdd: begin
                word = {rd_data, dly2}; // lane B lags lane A by one baseband sample
            end
            default: begin
                word = '0; // unused encoding keeps both lanes silent
            end
        endcase
    end

    // an empty FIFO drives zero so stale memory never reaches the converter
    assign dac_data  = rd_valid ? word : '0;
    assign dac_valid = rd_valid;

endmodule

// ==== design/dac_intf_top.sv ====
// top level of the transmit converter interface: pacer, dual-clock FIFO, flag sync, lane mapper
`timescale 1ns/1ps

module dac_intf_top #(
    parameter int iq_width        = tx_dac_pkg::iq_width,
    parameter int clk_per_sample  = 4, // acc_clk cycles per baseband sample
    parameter int fifo_addr_width = 5, // 32 entry FIFO
    parameter int sync_stages     = 4  // flag synchronizer depth
) (
    input  logic                    acc_clk,
    input  logic                    acc_rstn,
    input  logic                    dac_clk,
    input  logic                    dac_rst,
    input  logic                    tx_en,
    input  logic                    ant_flag,
    input  logic                    simple_cdd_flag,
    input  logic [2*iq_width-1:0]   data_from_acc,
    input  logic                    dac_ready,
    output logic                    read_bb_fifo,
    output logic                    read_bb_fifo_delay,
    output logic [4*iq_width-1:0]   dac_data,
    output logic                    dac_valid,
    output logic                    overflow
);

    logic                                wr_en;    // pacer write strobe, acc domain
    logic [tx_dac_pkg::sample_width-1:0] wr_data;
    logic [tx_dac_pkg::sample_width-1:0] rd_data;  // FIFO head, dac domain
    logic                                rd_valid;
    logic                                fifo_pop; // the one place where dac_ready gates the pop
    tx_dac_pkg::ant_mode_e               ant_mode;

    assign fifo_pop = rd_valid && dac_ready; // shared by FIFO and delay line so both advance together

    bb_sample_pacer #(
        .clk_per_sample(clk_per_sample)
    ) bb_sample_pacer_i (
        .acc_clk           (acc_clk),
        .acc_rstn          (acc_rstn),
        .tx_en             (tx_en),
        .data_from_acc     (data_from_acc),
        .read_bb_fifo      (read_bb_fifo),
        .read_bb_fifo_delay(read_bb_fifo_delay),
        .wr_en             (wr_en),
        .wr_data           (wr_data)
    );

    async_sample_fifo #(
        .fifo_addr_width(fifo_addr_width)
    ) async_sample_fifo_i (
        .acc_clk (acc_clk),
        .acc_rstn(acc_rstn),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .dac_clk (dac_clk),
        .dac_rst (dac_rst),
        .rd_en   (fifo_pop),
        .rd_data (rd_data),
        .rd_valid(rd_valid),
        .overflow(overflow)
    );

    ant_mode_sync #(
        .sync_stages(sync_stages)
    ) ant_mode_sync_i (
        .acc_clk        (acc_clk),
        .acc_rstn       (acc_rstn),
        .dac_clk        (dac_clk),
        .dac_rst        (dac_rst),
        .ant_flag       (ant_flag),
        .simple_cdd_flag(simple_cdd_flag),
        .ant_mode       (ant_mode)
    );

    dac_lane_mapper dac_lane_mapper_i (
        .dac_clk  (dac_clk),
        .dac_rst  (dac_rst),
        .pop      (fifo_pop),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .ant_mode (ant_mode),
        .dac_data (dac_data),
        .dac_valid(dac_valid)
    );

endmodule

// ==== verification/dac_intf_tb.sv ====
// testbench for dac_intf_top with clocks, reset, file-driven stream, upstream FIFO model and checks
`timescale 1ns/1ps

module dac_intf_tb;

    localparam int clk_per_sample = 4;
    localparam int sync_stages    = 4;
    localparam int max_rec        = 64; // room for the records of the data file

    logic        acc_clk;
    logic        acc_rstn;
    logic        dac_clk;
    logic        dac_rst;
    logic        tx_en;
    logic        ant_flag;
    logic        simple_cdd_flag;
    logic [31:0] data_from_acc;
    logic        dac_ready;
    logic        read_bb_fifo;
    logic        read_bb_fifo_delay;
    logic [63:0] dac_data;
    logic        dac_valid;
    logic        overflow;

    logic [63:0] tdata [0:5*max_rec-1]; // five entries per record with flags, sample and two words
    int          num_rec;
    int          beats;       // accepted converter beats so far
    int          pulses;      // read_bb_fifo pulses seen by the pacing monitor
    int          bb_idx;      // head of the upstream FIFO model
    int          gap;         // acc_clk cycles since the last pulse
    int          data_err;
    int          lane_err;
    int          pace_err;
    int          misc_err;
    int          rec;
    int          seg_end;
    int          rd_count;
    int unsigned rnd_seed;
    logic        pop_pending; // upstream pops on the edge after a pulse is seen
    logic        prev_pulse;
    logic        seg_start;   // first pulse of a segment has no spacing to check
    logic        ovf_seen;

    dac_intf_top #(
        .clk_per_sample(clk_per_sample),
        .sync_stages   (sync_stages)
    ) dac_intf_top_i (
        .acc_clk           (acc_clk),
        .acc_rstn          (acc_rstn),
        .dac_clk           (dac_clk),
        .dac_rst           (dac_rst),
        .tx_en             (tx_en),
        .ant_flag          (ant_flag),
        .simple_cdd_flag   (simple_cdd_flag),
        .data_from_acc     (data_from_acc),
        .dac_ready         (dac_ready),
        .read_bb_fifo      (read_bb_fifo),
        .read_bb_fifo_delay(read_bb_fifo_delay),
        .dac_data          (dac_data),
        .dac_valid         (dac_valid),
        .overflow          (overflow)
    );

    // popped stream is sample, zero, sample, zero, so odd entries and entries before 0 are zero
    function automatic logic [31:0] stream_entry(input int j);
        if (j < 0 || j % 2 == 1) return 32'h0;
        return tdata[5 * (j / 2) + 2][31:0];
    endfunction

    // converter word of beat j from the lane rules with lane A in the upper half
    function automatic logic [63:0] pack_lanes(input int j);
        logic ant;
        logic cdd;
        ant = tdata[5 * (j / 2)][0];
        cdd = tdata[5 * (j / 2) + 1][0];
        if (cdd) return {stream_entry(j), stream_entry(j - 2)}; // lane B two beats back
        if (ant) return {32'h0, stream_entry(j)};
        return {stream_entry(j), 32'h0};
    endfunction

    task automatic check_beat(input logic [63:0] word);
        logic [63:0] exp_file;
        if (beats >= 2 * num_rec) begin
            misc_err++;
            $display("converter beat %0d arrived after the last record, dac_data %h", beats, word);
        end else begin
            exp_file = tdata[5 * (beats / 2) + 3 + (beats % 2)]; // zero word on odd beats
            if (word !== exp_file) begin
                data_err++;
                $display("FAIL dac_data beat %0d expected %h actual %h", beats, exp_file, word);
            end
            if (word !== pack_lanes(beats)) begin
                lane_err++;
                $display("FAIL dac_data lanes beat %0d expected %h actual %h", beats,
                         pack_lanes(beats), word);
            end
        end
        beats++;
    endtask

    initial begin
        acc_clk = 1'b0;
        forever #4 acc_clk = ~acc_clk; // 8 ns processing clock
    end

    initial begin
        dac_clk = 1'b0;
        forever #3 dac_clk = ~dac_clk; // 6 ns converter clock that outpaces the writes
    end

    initial begin
        rnd_seed  = 32'he33f;
        rnd_seed  = $urandom(rnd_seed); // this process draws every ready value
        dac_ready = 1'b0;
        forever begin
            @(posedge dac_clk);
            #1;
            dac_ready = dac_rst ? 1'b0 : (($urandom % 4) != 0); // high about 3 beats in 4
        end
    end

    // upstream first-word-fall-through FIFO that pops on the edge where read_bb_fifo is high
    always @(posedge acc_clk) begin
        #1;
        if (pop_pending) begin
            bb_idx++;
            data_from_acc = (bb_idx < num_rec) ? tdata[5 * bb_idx + 2][31:0] : 32'h0;
        end
        pop_pending = (read_bb_fifo === 1'b1);
    end

    always @(negedge acc_clk) begin
        if (acc_rstn) begin
            gap++;
            if (read_bb_fifo_delay !== prev_pulse) begin
                pace_err++;
                $display("FAIL read_bb_fifo_delay expected %h actual %h", prev_pulse,
                         read_bb_fifo_delay);
            end
            if (read_bb_fifo === 1'b1) begin
                if (!seg_start && gap != clk_per_sample) begin
                    pace_err++;
                    $display("read_bb_fifo pulses came %0d cycles apart instead of %0d", gap,
                             clk_per_sample);
                end
                seg_start = 1'b0;
                gap       = 0;
                pulses++;
            end
            prev_pulse = read_bb_fifo;
            if (overflow !== 1'b0 && !ovf_seen) begin
                ovf_seen = 1'b1; // the level stays up until the next reset
                misc_err++;
                $display("FIFO overflow left zero although the reader outpaces the writer");
            end
        end
    end

    always @(negedge dac_clk) begin
        if (!dac_rst && dac_valid === 1'b1 && dac_ready === 1'b1) begin
            check_beat(dac_data); // accepted on the coming rising edge
        end
    end

    initial begin
        #1;
        #(num_rec * 2 * clk_per_sample * 8 * 4 + 2000); // generous bound on the whole stream
        $display("timeout: only %0d of %0d converter beats accepted", beats, 2 * num_rec);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        acc_rstn        = 1'b0;
        dac_rst         = 1'b1;
        tx_en           = 1'b0;
        ant_flag        = 1'b0;
        simple_cdd_flag = 1'b0;
        data_from_acc   = 32'h0;
        beats           = 0;
        pulses          = 0;
        bb_idx          = 0;
        gap             = 0;
        data_err        = 0;
        lane_err        = 0;
        pace_err        = 0;
        misc_err        = 0;
        pop_pending     = 1'b0;
        prev_pulse      = 1'b0;
        seg_start       = 1'b0;
        ovf_seen        = 1'b0;
        $readmemh("verification/dac_intf_testdata.txt", tdata);
        num_rec = 0;
        while (num_rec < max_rec && !$isunknown(tdata[5 * num_rec])) begin
            num_rec++; // records end at the first unloaded entry
        end
        if (num_rec > 0) begin
            data_from_acc = tdata[2][31:0];
        end else begin
            misc_err++;
            $display("no records were read from the stimulus file");
        end
        repeat (3) @(posedge acc_clk);
        #1;
        acc_rstn = 1'b1;
        @(posedge dac_clk);
        #1;
        dac_rst = 1'b0;
        @(negedge acc_clk);
        if (read_bb_fifo !== 1'b0 || dac_valid !== 1'b0 || overflow !== 1'b0) begin
            misc_err++;
            $display("read_bb_fifo, dac_valid or overflow is not low after reset");
        end
        rec = 0;
        while (rec < num_rec) begin
            seg_end = rec;
            while (seg_end < num_rec && tdata[5 * seg_end][0] == tdata[5 * rec][0]
                   && tdata[5 * seg_end + 1][0] == tdata[5 * rec + 1][0]) begin
                seg_end++; // segment runs while both flags stay the same
            end
            @(posedge acc_clk);
            #1;
            ant_flag        = tdata[5 * rec][0];
            simple_cdd_flag = tdata[5 * rec + 1][0];
            repeat (sync_stages + 4) @(posedge dac_clk); // mode settles before the stream
            if (dac_intf_top_i.bb_sample_pacer_i.phase != tx_dac_pkg::ph_idle) begin
                misc_err++;
                $display("pacer is not in ph_idle before the segment at record %0d", rec);
            end
            $display("segment from record %0d to %0d, ant_flag %0d simple_cdd_flag %0d", rec,
                     seg_end - 1, ant_flag, simple_cdd_flag);
            @(posedge acc_clk);
            #1;
            seg_start = 1'b1;
            tx_en     = 1'b1;
            rd_count  = rec;
            while (rd_count < seg_end) begin
                @(posedge acc_clk);
                #1;
                if (read_bb_fifo === 1'b1) begin
                    rd_count++;
                end
            end
            tx_en = 1'b0; // the last period still finishes its two writes
            while (beats < 2 * seg_end || dac_valid !== 1'b0) begin
                @(negedge dac_clk);
            end
            rec = seg_end;
        end
        repeat (4 * clk_per_sample) @(posedge acc_clk);
        if (pulses != num_rec) begin
            misc_err++;
            $display("saw %0d read_bb_fifo pulses for %0d records", pulses, num_rec);
        end
        if (beats != 2 * num_rec) begin
            misc_err++;
            $display("accepted %0d converter beats instead of %0d", beats, 2 * num_rec);
        end
        $display("errors: data %0d, lanes %0d, pacing %0d, other %0d", data_err, lane_err,
                 pace_err, misc_err);
        if (data_err + lane_err + pace_err + misc_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/tx_dac_pkg.sv
design/bb_sample_pacer.sv
design/async_sample_fifo.sv
design/ant_mode_sync.sv
design/dac_lane_mapper.sv
design/dac_intf_top.sv
verification/dac_intf_tb.sv

// ==== verification/dac_intf_testdata.txt ====
// columns: ant_flag simple_cdd_flag sample(I upper, Q lower) word_on_sample_beat word_on_zero_beat
// words are lane A (upper 32 bits) then lane B (lower 32 bits), every value in hex
0 0 1111aaaa 1111aaaa00000000 0000000000000000
0 0 2222bbbb 2222bbbb00000000 0000000000000000
0 0 3333cccc 3333cccc00000000 0000000000000000
0 0 4444dddd 4444dddd00000000 0000000000000000
0 0 5555eeee 5555eeee00000000 0000000000000000
1 0 0001fff0 000000000001fff0 0000000000000000
1 0 7fff8001 000000007fff8001 0000000000000000
1 0 00640064 0000000000640064 0000000000000000
1 0 ff9c0032 00000000ff9c0032 0000000000000000
// CDD lane B carries the previous baseband sample, across the segment change too
0 1 12340567 12340567ff9c0032 0000000000000000
0 1 89ab0cde 89ab0cde12340567 0000000000000000
0 1 0f0f7070 0f0f707089ab0cde 0000000000000000
0 1 a5a55a5a a5a55a5a0f0f7070 0000000000000000
0 1 deadbeef deadbeefa5a55a5a 0000000000000000
0 0 c0de1234 c0de123400000000 0000000000000000
0 0 00010002 0001000200000000 0000000000000000
0 0 fffe0003 fffe000300000000 0000000000000000
1 1 13579bdf 13579bdffffe0003 0000000000000000
1 1 2468ace0 2468ace013579bdf 0000000000000000
1 1 80007fff 80007fff2468ace0 0000000000000000
1 1 00000001 0000000180007fff 0000000000000000
1 0 abcd1234 00000000abcd1234 0000000000000000
1 0 1234abcd 000000001234abcd 0000000000000000
1 0 7ffe8002 000000007ffe8002 0000000000000000
